//--- rtl/dp_pkg.sv
// Datapath shared definitions
package dp_pkg;

    // ------------------------------------------------------------------------
    // Widths and address map

    localparam int WORD_WIDTH       = 16;
    localparam int MEM_ADDR_WIDTH   = 8;
    localparam int WRITE_ADDR_WIDTH = 9;
    localparam int COUNT_WIDTH      = 16;
    localparam int MEM_DEPTH        = 256;

    // Ports sit at the same low address in both the A and B ranges
    localparam int IO_PORT_COUNT    = 2;
    localparam int IO_PORT_BASE     = 240;

    localparam int S_ADDR           = 255;
    localparam int NULL_ADDR        = 0;

    // ------------------------------------------------------------------------
    // Types

    typedef logic [WORD_WIDTH-1:0]       word_t;
    typedef logic [MEM_ADDR_WIDTH-1:0]   mem_addr_t;
    // Bit 8 selects memory B
    typedef logic [WRITE_ADDR_WIDTH-1:0] write_addr_t;
    typedef logic [IO_PORT_COUNT-1:0]    io_mask_t;
    typedef logic [COUNT_WIDTH-1:0]      count_t;

    typedef enum logic [2:0] {
        ADD    = 3'd0,
        SUB    = 3'd1,
        AND    = 3'd2,
        OR     = 3'd3,
        XOR    = 3'd4,
        ADD_S  = 3'd5,
        PASS_A = 3'd6
    } alu_op_t;

    typedef struct packed {
        logic        valid;
        alu_op_t     op;
        mem_addr_t   read_a;
        mem_addr_t   read_b;
        write_addr_t write_d;
    } instr_t;

    typedef struct packed {
        logic        valid;
        write_addr_t write_addr;
        word_t       data;
        logic        carry;
        logic        overflow;
    } result_t;

    // ------------------------------------------------------------------------
    // Port decode, one-hot on the port named by a per-memory address

    function automatic io_mask_t port_onehot(mem_addr_t addr);
        io_mask_t mask;
        for (int p = 0; p < IO_PORT_COUNT; p++) begin
            mask[p] = (addr == mem_addr_t'(IO_PORT_BASE + p));
        end
        return mask;
    endfunction

    function automatic logic addr_is_io(mem_addr_t addr);
        return |port_onehot(addr);
    endfunction

endpackage

//--- rtl/pipe_delay.sv
// Control delay line
`timescale 1ns/100ps

module pipe_delay #(
    parameter int DEPTH = 2,
    parameter int WIDTH = 8
) (
    input  logic             clock,
    input  logic             rst,
    input  logic [WIDTH-1:0] in_data,
    output logic [WIDTH-1:0] out_data
);

    logic [WIDTH-1:0] shift [DEPTH];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                shift[i] <= '0;
            end
        end else begin
            shift[0] <= in_data;
            for (int i = 1; i < DEPTH; i++) begin
                shift[i] <= shift[i-1];
            end
        end
    end

    assign out_data = shift[DEPTH-1];

endmodule

//--- rtl/io_predication.sv
// I/O predication and annulment
`timescale 1ns/100ps

module io_predication
    import dp_pkg::*;
(
    input  logic     clock,
    input  logic     rst,
    input  instr_t   instr,
    input  logic     cancel,
    input  io_mask_t read_ready_a,
    input  io_mask_t read_ready_b,
    input  io_mask_t write_ready_a,
    input  io_mask_t write_ready_b,
    output io_mask_t io_rden_a,
    output io_mask_t io_rden_b,
    output instr_t   stage,
    output logic     read_is_io_a,
    output logic     read_is_io_b,
    output io_mask_t read_port_a,
    output io_mask_t read_port_b,
    output logic     annulled
);

    io_mask_t port_a;
    io_mask_t port_b;
    io_mask_t port_d;
    io_mask_t write_ready_d;
    logic     ready;
    logic     make_noop;

    // ------------------------------------------------------------------------
    // Decode and readiness

    assign port_a = port_onehot(instr.read_a);
    assign port_b = port_onehot(instr.read_b);
    assign port_d = port_onehot(instr.write_d[MEM_ADDR_WIDTH-1:0]);

    // The top address bit picks which side's write flags apply
    assign write_ready_d = instr.write_d[MEM_ADDR_WIDTH] ? write_ready_b : write_ready_a;

    // Each named port must have its flag set; a non-I/O address has no mask bits
    always_comb begin
        ready = 1'b1;
        if ((port_a & ~read_ready_a) != '0) ready = 1'b0;
        if ((port_b & ~read_ready_b) != '0) ready = 1'b0;
        if ((port_d & ~write_ready_d) != '0) ready = 1'b0;
    end

    // An idle slot is treated as a no-op as well, so it reads and writes nothing
    assign make_noop = !instr.valid || !ready || cancel;

    // ------------------------------------------------------------------------
    // Registered stage, all addresses forced to null on a no-op

    always_ff @(posedge clock) begin
        if (rst) begin
            stage        <= '0;
            read_is_io_a <= 1'b0;
            read_is_io_b <= 1'b0;
            read_port_a  <= '0;
            read_port_b  <= '0;
            annulled     <= 1'b0;
        end else begin
            stage.valid   <= !make_noop;
            stage.op      <= instr.op;
            stage.read_a  <= make_noop ? mem_addr_t'(NULL_ADDR) : instr.read_a;
            stage.read_b  <= make_noop ? mem_addr_t'(NULL_ADDR) : instr.read_b;
            stage.write_d <= make_noop ? write_addr_t'(NULL_ADDR) : instr.write_d;
            read_is_io_a  <= !make_noop && addr_is_io(instr.read_a);
            read_is_io_b  <= !make_noop && addr_is_io(instr.read_b);
            read_port_a   <= make_noop ? '0 : port_a;
            read_port_b   <= make_noop ? '0 : port_b;
            // Cancelled instructions are not counted as annulled
            annulled      <= instr.valid && !ready && !cancel;
        end
    end

    // The read strobe is the selected port itself, held for the one stage cycle
    assign io_rden_a = read_port_a;
    assign io_rden_b = read_port_b;

endmodule

//--- rtl/operand_memory.sv
// Operand memories A and B
`timescale 1ns/100ps

module operand_memory
    import dp_pkg::*;
(
    input  logic                         clock,
    input  instr_t                       stage,
    input  logic                         read_is_io_a,
    input  logic                         read_is_io_b,
    input  io_mask_t                     read_port_a,
    input  io_mask_t                     read_port_b,
    input  word_t    [IO_PORT_COUNT-1:0] io_read_data_a,
    input  word_t    [IO_PORT_COUNT-1:0] io_read_data_b,
    input  result_t                      wb,
    output io_mask_t                     io_wren_a,
    output io_mask_t                     io_wren_b,
    output word_t                        io_write_data,
    output word_t                        read_data_a,
    output word_t                        read_data_b
);

    mem_addr_t rd_addr [2];
    logic      rd_is_io [2];
    io_mask_t  rd_port [2];
    word_t     [IO_PORT_COUNT-1:0] io_data [2];
    word_t     rd_data [2];

    mem_addr_t wr_low;
    logic      wr_is_b;
    io_mask_t  wr_port;
    logic      mem_we;

    // Bank 0 is memory A and bank 1 is memory B
    assign rd_addr[0]  = stage.read_a;
    assign rd_addr[1]  = stage.read_b;
    assign rd_is_io[0] = read_is_io_a;
    assign rd_is_io[1] = read_is_io_b;
    assign rd_port[0]  = read_port_a;
    assign rd_port[1]  = read_port_b;
    assign io_data[0]  = io_read_data_a;
    assign io_data[1]  = io_read_data_b;
    assign read_data_a = rd_data[0];
    assign read_data_b = rd_data[1];

    // ------------------------------------------------------------------------
    // Write-back decode

    assign wr_low  = wb.write_addr[MEM_ADDR_WIDTH-1:0];
    assign wr_is_b = wb.write_addr[MEM_ADDR_WIDTH];
    assign wr_port = port_onehot(wr_low);

    // Port addresses go out as write strobes and never touch the arrays
    assign mem_we = wb.valid && !addr_is_io(wr_low) && (wr_low != mem_addr_t'(NULL_ADDR));

    assign io_wren_a     = (wb.valid && !wr_is_b) ? wr_port : '0;
    assign io_wren_b     = (wb.valid && wr_is_b) ? wr_port : '0;
    assign io_write_data = wb.data;

    // ------------------------------------------------------------------------
    // Banks

    for (genvar bank = 0; bank < 2; bank++) begin : g_bank
        word_t mem [MEM_DEPTH];
        word_t io_word;

        always_comb begin
            io_word = '0;
            for (int p = 0; p < IO_PORT_COUNT; p++) begin
                if (rd_port[bank][p]) io_word = io_data[bank][p];
            end
        end

        always_ff @(posedge clock) begin
            if (mem_we && (wr_is_b == 1'(bank))) begin
                mem[wr_low] <= wb.data;
            end
        end

        // Address zero always reads as zero
        always_ff @(posedge clock) begin
            if (rd_is_io[bank]) begin
                rd_data[bank] <= io_word;
            end else if (rd_addr[bank] == mem_addr_t'(NULL_ADDR)) begin
                rd_data[bank] <= '0;
            end else begin
                rd_data[bank] <= mem[rd_addr[bank]];
            end
        end
    end

endmodule

//--- rtl/alu.sv
// Two-stage ALU
`timescale 1ns/100ps

module alu
    import dp_pkg::*;
(
    input  logic    clock,
    input  logic    rst,
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    input  word_t   s,
    output result_t out
);

    localparam int MSB = WORD_WIDTH - 1;

    alu_op_t             op_q;
    word_t               a_q;
    word_t               b_q;
    word_t               s_q;
    logic [WORD_WIDTH:0] wide;
    logic                ovf;
    word_t               data_q;
    logic                carry_q;
    logic                ovf_q;

    // ------------------------------------------------------------------------
    // Stage 1 latches operands and operation

    always_ff @(posedge clock) begin
        if (rst) begin
            op_q <= PASS_A;
        end else begin
            op_q <= op;
        end
        a_q <= a;
        b_q <= b;
        s_q <= s;
    end

    // ------------------------------------------------------------------------
    // Stage 2 computes. On SUB the carry bit is the borrow out of the top bit

    always_comb begin
        wide = '0;
        ovf  = 1'b0;
        case (op_q)
            ADD: begin
                wide = {1'b0, a_q} + {1'b0, b_q};
                ovf  = (a_q[MSB] == b_q[MSB]) && (wide[MSB] != a_q[MSB]);
            end
            SUB: begin
                wide = {1'b0, a_q} - {1'b0, b_q};
                ovf  = (a_q[MSB] != b_q[MSB]) && (wide[MSB] != a_q[MSB]);
            end
            ADD_S: begin
                wide = {1'b0, a_q} + {1'b0, s_q};
                ovf  = (a_q[MSB] == s_q[MSB]) && (wide[MSB] != a_q[MSB]);
            end
            AND:     wide = {1'b0, a_q & b_q};
            OR:      wide = {1'b0, a_q | b_q};
            XOR:     wide = {1'b0, a_q ^ b_q};
            default: wide = {1'b0, a_q};
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            carry_q <= 1'b0;
            ovf_q   <= 1'b0;
        end else begin
            carry_q <= wide[WORD_WIDTH];
            ovf_q   <= ovf;
        end
        data_q <= wide[MSB:0];
    end

    // Valid and write address are attached at the top from the address pipe
    assign out = '{valid: 1'b0, write_addr: '0, data: data_q, carry: carry_q, overflow: ovf_q};

endmodule

//--- rtl/alu_registers.sv
// S register and annul counter
`timescale 1ns/100ps

module alu_registers
    import dp_pkg::*;
(
    input  logic    clock,
    input  logic    rst,
    input  result_t wb,
    input  logic    annulled,
    output word_t   s,
    output count_t  annul_count
);

    logic s_we;

    // S is memory-mapped at the top of the A range
    assign s_we = wb.valid && (wb.write_addr == write_addr_t'(S_ADDR));

    always_ff @(posedge clock) begin
        if (rst) begin
            s           <= '0;
            annul_count <= '0;
        end else begin
            if (s_we) begin
                s <= wb.data;
            end
            // Saturates rather than wrapping
            if (annulled && (annul_count != '1)) begin
                annul_count <= annul_count + 1'b1;
            end
        end
    end

endmodule

//--- rtl/datapath.sv
// Datapath top level
`timescale 1ns/100ps

module datapath
    import dp_pkg::*;
(
    input  logic                         clock,
    input  logic                         rst,
    input  instr_t                       instr,
    input  logic                         cancel,
    input  io_mask_t                     io_read_ready_a,
    input  io_mask_t                     io_read_ready_b,
    input  io_mask_t                     io_write_ready_a,
    input  io_mask_t                     io_write_ready_b,
    input  word_t    [IO_PORT_COUNT-1:0] io_read_data_a,
    input  word_t    [IO_PORT_COUNT-1:0] io_read_data_b,
    output io_mask_t                     io_rden_a,
    output io_mask_t                     io_rden_b,
    output io_mask_t                     io_wren_a,
    output io_mask_t                     io_wren_b,
    output word_t                        io_write_data,
    output result_t                      result,
    output logic                         annulled,
    output count_t                       annul_count
);

    instr_t                   stage;
    logic                     read_is_io_a;
    logic                     read_is_io_b;
    io_mask_t                 read_port_a;
    io_mask_t                 read_port_b;
    word_t                    read_data_a;
    word_t                    read_data_b;
    logic [$bits(alu_op_t)-1:0] alu_op_bits;
    write_addr_t              wb_addr;
    result_t                  alu_out;
    word_t                    s;

    // ------------------------------------------------------------------------
    // Issue stage

    io_predication u_io_predication (
        .clock         (clock),
        .rst           (rst),
        .instr         (instr),
        .cancel        (cancel),
        .read_ready_a  (io_read_ready_a),
        .read_ready_b  (io_read_ready_b),
        .write_ready_a (io_write_ready_a),
        .write_ready_b (io_write_ready_b),
        .io_rden_a     (io_rden_a),
        .io_rden_b     (io_rden_b),
        .stage         (stage),
        .read_is_io_a  (read_is_io_a),
        .read_is_io_b  (read_is_io_b),
        .read_port_a   (read_port_a),
        .read_port_b   (read_port_b),
        .annulled      (annulled)
    );

    operand_memory u_operand_memory (
        .clock          (clock),
        .stage          (stage),
        .read_is_io_a   (read_is_io_a),
        .read_is_io_b   (read_is_io_b),
        .read_port_a    (read_port_a),
        .read_port_b    (read_port_b),
        .io_read_data_a (io_read_data_a),
        .io_read_data_b (io_read_data_b),
        .wb             (result),
        .io_wren_a      (io_wren_a),
        .io_wren_b      (io_wren_b),
        .io_write_data  (io_write_data),
        .read_data_a    (read_data_a),
        .read_data_b    (read_data_b)
    );

    // ------------------------------------------------------------------------
    // Control pipes. The op is taken raw so it reaches ALU stage 1 at E2

    pipe_delay #(.DEPTH(2), .WIDTH($bits(alu_op_t))) u_op_pipe (
        .clock    (clock),
        .rst      (rst),
        .in_data  (instr.op),
        .out_data (alu_op_bits)
    );

    // The annulled write address lines up with the ALU output after E3
    pipe_delay #(.DEPTH(3), .WIDTH($bits(write_addr_t))) u_addr_pipe (
        .clock    (clock),
        .rst      (rst),
        .in_data  (stage.write_d),
        .out_data (wb_addr)
    );

    alu u_alu (
        .clock (clock),
        .rst   (rst),
        .op    (alu_op_t'(alu_op_bits)),
        .a     (read_data_a),
        .b     (read_data_b),
        .s     (s),
        .out   (alu_out)
    );

    alu_registers u_alu_registers (
        .clock       (clock),
        .rst         (rst),
        .wb          (result),
        .annulled    (annulled),
        .s           (s),
        .annul_count (annul_count)
    );

    // A null destination marks a no-op slot
    always_comb begin
        result            = alu_out;
        result.write_addr = wb_addr;
        result.valid      = (wb_addr != write_addr_t'(NULL_ADDR));
    end

endmodule

//--- verif/tb_clock.sv
// Testbench clock and reset
`timescale 1ns/100ps

module tb_clock (
    output logic clock,
    output logic rst
);

    localparam real HALF_PERIOD = 2.0;

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

    // Reset is held over two rising edges and released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
    end

endmodule

//--- verif/tb_datapath.sv
// Datapath testbench
`timescale 1ns/100ps

module tb_datapath
    import dp_pkg::*;
();

    localparam int LOAD_COUNT     = 16;
    localparam int RANDOM_COUNT   = 40;
    localparam int ADD_S_COUNT    = 4;
    localparam int ISSUE_COUNT    = LOAD_COUNT + RANDOM_COUNT + 1 + ADD_S_COUNT + 4;
    localparam int TIMEOUT_CYCLES = ISSUE_COUNT * 2 + 100;

    typedef struct packed {
        int       cycle;
        result_t  res;
        io_mask_t rden_a;
        io_mask_t rden_b;
        logic     annulled;
        io_mask_t wren_a;
        io_mask_t wren_b;
    } expect_t;

    logic                       clock;
    logic                       rst;
    instr_t                     instr;
    logic                       cancel;
    io_mask_t                   read_ready_a;
    io_mask_t                   read_ready_b;
    io_mask_t                   write_ready_a;
    io_mask_t                   write_ready_b;
    word_t  [IO_PORT_COUNT-1:0] read_data_a;
    word_t  [IO_PORT_COUNT-1:0] read_data_b;
    io_mask_t                   rden_a;
    io_mask_t                   rden_b;
    io_mask_t                   wren_a;
    io_mask_t                   wren_b;
    word_t                      write_data;
    result_t                    result;
    logic                       annulled;
    count_t                     annul_count;

    // Model state, updated when an instruction issues
    word_t       mem_model [2][MEM_DEPTH];
    word_t       s_model;
    count_t      count_model;
    write_addr_t recent_dest [3];
    logic [31:0] lcg_state;
    int          cycle;
    expect_t     rden_q [$];
    expect_t     result_q [$];

    tb_clock u_clock (
        .clock (clock),
        .rst   (rst)
    );

    datapath UUT (
        .clock            (clock),
        .rst              (rst),
        .instr            (instr),
        .cancel           (cancel),
        .io_read_ready_a  (read_ready_a),
        .io_read_ready_b  (read_ready_b),
        .io_write_ready_a (write_ready_a),
        .io_write_ready_b (write_ready_b),
        .io_read_data_a   (read_data_a),
        .io_read_data_b   (read_data_b),
        .io_rden_a        (rden_a),
        .io_rden_b        (rden_b),
        .io_wren_a        (wren_a),
        .io_wren_b        (wren_b),
        .io_write_data    (write_data),
        .result           (result),
        .annulled         (annulled),
        .annul_count      (annul_count)
    );

    // ------------------------------------------------------------------------
    // Helpers and reference model

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {16'd0, lcg_state[30:15]};
    endfunction

    function automatic int port_index(mem_addr_t addr);
        int offset;
        offset = int'(addr) - IO_PORT_BASE;
        if (offset >= 0 && offset < IO_PORT_COUNT) return offset;
        return -1;
    endfunction

    function automatic io_mask_t port_mask(int idx);
        if (idx < 0) return '0;
        return io_mask_t'(1 << idx);
    endfunction

    function automatic word_t model_read(int side, mem_addr_t addr);
        int p;
        p = port_index(addr);
        if (addr == '0) return '0;
        if (p >= 0) return (side == 0) ? read_data_a[p] : read_data_b[p];
        return mem_model[side][addr];
    endfunction

    // Carry on SUB is the borrow, so it is set when A is below B
    function automatic result_t reference_result(alu_op_t op, word_t a, word_t b, word_t s,
                                                 write_addr_t dest);
        result_t r;
        word_t   rhs;
        int      sum;
        int      signed_sum;
        r            = '0;
        r.valid      = (dest != '0);
        r.write_addr = dest;
        rhs          = (op == ADD_S) ? s : b;
        case (op)
            ADD, ADD_S: begin
                sum        = int'(a) + int'(rhs);
                signed_sum = int'($signed(a)) + int'($signed(rhs));
                r.data     = word_t'(sum);
                r.carry    = (sum > 65535);
                r.overflow = (signed_sum > 32767) || (signed_sum < -32768);
            end
            SUB: begin
                signed_sum = int'($signed(a)) - int'($signed(rhs));
                r.data     = a - rhs;
                r.carry    = (a < rhs);
                r.overflow = (signed_sum > 32767) || (signed_sum < -32768);
            end
            AND:     r.data = a & rhs;
            OR:      r.data = a | rhs;
            XOR:     r.data = a ^ rhs;
            default: r.data = a;
        endcase
        return r;
    endfunction

    function automatic instr_t make_instr(alu_op_t op, mem_addr_t ra, mem_addr_t rb,
                                          write_addr_t wd);
        instr_t ins;
        ins.valid   = 1'b1;
        ins.op      = op;
        ins.read_a  = ra;
        ins.read_b  = rb;
        ins.write_d = wd;
        return ins;
    endfunction

    // A read must not target a write that is still in the pipeline
    function automatic logic has_hazard(instr_t ins);
        for (int i = 0; i < 3; i++) begin
            if (recent_dest[i] != '0) begin
                if (ins.read_a != '0 && recent_dest[i] == {1'b0, ins.read_a}) return 1'b1;
                if (ins.read_b != '0 && recent_dest[i] == {1'b1, ins.read_b}) return 1'b1;
                if (ins.op == ADD_S && recent_dest[i] == write_addr_t'(S_ADDR)) return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // ------------------------------------------------------------------------
    // Compare tasks

    task automatic raise_error();
        $display("sim failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_result(string name, result_t got, result_t exp);
        if (exp.valid ? (got !== exp) : (got.valid !== 1'b0)) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            raise_error();
        end
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            raise_error();
        end
    endtask

    task automatic check_mask(string name, io_mask_t got, io_mask_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            raise_error();
        end
    endtask

    task automatic check_count(string name, count_t got, count_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            raise_error();
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            raise_error();
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus tasks. Each call drives one slot at a falling edge

    task automatic drive_slot(instr_t ins, logic cancel_bit);
        expect_t e;
        int      pa;
        int      pb;
        int      pd;
        logic    ready;
        logic    noop;
        pa    = port_index(ins.read_a);
        pb    = port_index(ins.read_b);
        pd    = port_index(ins.write_d[MEM_ADDR_WIDTH-1:0]);
        ready = 1'b1;
        if (pa >= 0 && !read_ready_a[pa]) ready = 1'b0;
        if (pb >= 0 && !read_ready_b[pb]) ready = 1'b0;
        if (pd >= 0) begin
            if (ins.write_d[MEM_ADDR_WIDTH] ? !write_ready_b[pd] : !write_ready_a[pd]) begin
                ready = 1'b0;
            end
        end
        noop       = !ins.valid || !ready || cancel_bit;
        e          = '0;
        e.cycle    = cycle;
        e.annulled = ins.valid && !ready && !cancel_bit;
        if (e.annulled) count_model++;
        if (!noop) begin
            e.rden_a = port_mask(pa);
            e.rden_b = port_mask(pb);
            e.res    = reference_result(ins.op, model_read(0, ins.read_a),
                                        model_read(1, ins.read_b), s_model, ins.write_d);
            if (e.res.valid && pd >= 0) begin
                if (ins.write_d[MEM_ADDR_WIDTH]) e.wren_b = port_mask(pd);
                else e.wren_a = port_mask(pd);
            end else if (e.res.valid) begin
                mem_model[int'(ins.write_d[MEM_ADDR_WIDTH])]
                         [ins.write_d[MEM_ADDR_WIDTH-1:0]] = e.res.data;
                if (ins.write_d == write_addr_t'(S_ADDR)) s_model = e.res.data;
            end
        end
        recent_dest[2] = recent_dest[1];
        recent_dest[1] = recent_dest[0];
        recent_dest[0] = noop ? '0 : ins.write_d;
        rden_q.push_back(e);
        result_q.push_back(e);
        instr  = ins;
        cancel = cancel_bit;
        @(negedge clock);
    endtask

    task automatic idle_cycle();
        drive_slot('0, 1'b0);
    endtask

    task automatic send_when_clear(instr_t ins);
        while (has_hazard(ins)) idle_cycle();
        drive_slot(ins, 1'b0);
    endtask

    // ------------------------------------------------------------------------
    // Compare process, one and four cycles after each slot

    initial begin
        expect_t e;
        forever begin
            @(negedge clock);
            if (rden_q.size() > 0 && rden_q[0].cycle == cycle - 1) begin
                e = rden_q.pop_front();
                check_mask("io_rden_a", rden_a, e.rden_a);
                check_mask("io_rden_b", rden_b, e.rden_b);
                check_bit("annulled", annulled, e.annulled);
            end
            if (result_q.size() > 0 && result_q[0].cycle == cycle - 4) begin
                e = result_q.pop_front();
                check_result("result", result, e.res);
                check_mask("io_wren_a", wren_a, e.wren_a);
                check_mask("io_wren_b", wren_b, e.wren_b);
                if ((e.wren_a | e.wren_b) != '0) begin
                    check_word("io_write_data", write_data, e.res.data);
                end
            end
        end
    end

    initial begin
        cycle = 0;
        while (cycle < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle = cycle + 1;
        end
        $display("sim failed");
        $fatal(1, "Timeout after %0d cycles without reaching the end of the tests", cycle);
    end

    // ------------------------------------------------------------------------
    // Main sequence

    initial begin
        instr_t ins;
        word_t  old_word;
        count_t count_before;
        int     port;
        instr         = '0;
        cancel        = 1'b0;
        read_ready_a  = 2'b11;
        read_ready_b  = 2'b00;
        write_ready_a = 2'b00;
        write_ready_b = 2'b00;
        read_data_a   = '0;
        read_data_b   = '0;
        s_model       = '0;
        count_model   = '0;
        lcg_state     = 32'd90683;
        for (int i = 0; i < 3; i++) recent_dest[i] = '0;
        @(negedge rst);

        // Load A[1..8] and B[1..8] from the two A-side ports in turn
        for (int i = 0; i < LOAD_COUNT; i++) begin
            port              = i % 2;
            read_data_a[port] = word_t'(next_random());
            ins = make_instr(PASS_A, mem_addr_t'(IO_PORT_BASE + port), '0,
                             write_addr_t'((i / 8) * 256 + (i % 8) + 1));
            send_when_clear(ins);
        end

        // Random logic and arithmetic on the loaded words
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            ins = make_instr(alu_op_t'(3'(next_random() % 5)),
                             mem_addr_t'(1 + next_random() % 8),
                             mem_addr_t'(1 + next_random() % 8),
                             write_addr_t'((next_random() % 2) * 256 + 1 + next_random() % 8));
            send_when_clear(ins);
        end

        // S register, then reads of S through ADD_S
        send_when_clear(make_instr(PASS_A, mem_addr_t'(1 + next_random() % 8), '0,
                                   write_addr_t'(S_ADDR)));
        for (int i = 0; i < ADD_S_COUNT; i++) begin
            send_when_clear(make_instr(ADD_S, mem_addr_t'(1 + next_random() % 8), '0,
                                       write_addr_t'(10 + i)));
        end

        // Port 1 on side A is not ready, so the write to A[3] must vanish
        read_ready_a = 2'b01;
        send_when_clear(make_instr(PASS_A, mem_addr_t'(IO_PORT_BASE + 1), '0,
                                   write_addr_t'(3)));
        read_ready_a = 2'b11;
        send_when_clear(make_instr(PASS_A, mem_addr_t'(3), '0, write_addr_t'(9)));
        repeat (3) idle_cycle();
        check_count("annul_count", annul_count, count_model);

        // A ready port read with cancel high leaves no trace
        count_before = count_model;
        drive_slot(make_instr(PASS_A, mem_addr_t'(IO_PORT_BASE), '0, write_addr_t'(4)), 1'b1);
        repeat (3) idle_cycle();
        check_count("annul_count", annul_count, count_before);

        // Write to port 1 on side B, which stays ready until the strobe is seen
        old_word      = UUT.u_operand_memory.g_bank[1].mem[IO_PORT_BASE + 1];
        write_ready_b = 2'b10;
        send_when_clear(make_instr(ADD, mem_addr_t'(1), mem_addr_t'(2),
                                   write_addr_t'(256 + IO_PORT_BASE + 1)));
        repeat (5) idle_cycle();
        write_ready_b = 2'b00;
        check_word("mem_b[241]", UUT.u_operand_memory.g_bank[1].mem[IO_PORT_BASE + 1],
                   old_word);

        while (rden_q.size() > 0 || result_q.size() > 0) @(negedge clock);

        $display("sim passed");
        $finish;
    end

endmodule

//--- tb.f
rtl/dp_pkg.sv
rtl/pipe_delay.sv
rtl/io_predication.sv
rtl/operand_memory.sv
rtl/alu.sv
rtl/alu_registers.sv
rtl/datapath.sv
verif/tb_clock.sv
verif/tb_datapath.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and decide the outcome from the log
rm -f sim.log
verilator --binary --timing -f tb.f --top-module tb_datapath -o sim_datapath \
    && ./obj_dir/sim_datapath | tee sim.log
grep -qx "sim passed" sim.log && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }
